//--- include/wb_mux_cfg.svh
`ifndef WB_MUX_CFG_SVH
`define WB_MUX_CFG_SVH

// Highest team number, team 0 is never populated
`define NUM_TEAMS 4

// Region codes on address bits 31:16 (31:24 for designs)
`define REGION_DESIGN 8'h30
`define REGION_LA 16'h3100
`define REGION_GPIO 16'h3200

`define GPIO_WIDTH 16

// LA and GPIO control register map
`define OFS_DATA 16'h0000
`define OFS_OEN 16'h0004
`define OFS_IN 16'h0008

// Team slot register map
`define OFS_SCRATCH 16'h0000
`define OFS_ID 16'h0004
`define OFS_COUNT 16'h0008

`endif

//--- rtl/wb_mux_pkg.sv
`include "wb_mux_cfg.svh"

package wb_mux_pkg;

    // Full bus address and data words
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Offset inside one target region
    typedef logic [15:0] reg_offset_t;

    // Team number field, address bits 23:16
    typedef logic [7:0] team_sel_t;

    // One bit per GPIO pad
    typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

    // Per-slave acknowledge state
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_t;

endpackage

//--- rtl/wb_interconnect.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module wb_interconnect (
    // Master side
    input  logic                                wbs_stb_i,
    input  wb_mux_pkg::wb_addr_t                wbs_adr_i,
    output logic                                wbs_ack_o,
    output wb_mux_pkg::wb_data_t                wbs_dat_o,

    // Decoded strobes
    output logic [`NUM_TEAMS:0]                 designs_stb_o,
    output logic                                la_control_stb_o,
    output logic                                gpio_control_stb_o,

    // Offset seen by every slave
    output wb_mux_pkg::wb_addr_t                adr_truncated_o,

    // Read data from the targets, teams packed 32 bits each
    input  logic [32*(`NUM_TEAMS+1)-1:0]        designs_wbs_dat_o_flat,
    input  wb_mux_pkg::wb_data_t                la_control_dat_i,
    input  wb_mux_pkg::wb_data_t                gpio_control_dat_i,

    // Acknowledges from the targets
    input  logic [`NUM_TEAMS:0]                 designs_ack_i,
    input  logic                                la_control_ack_i,
    input  logic                                gpio_control_ack_i
);

    wb_mux_pkg::team_sel_t team_sel;
    wb_mux_pkg::wb_data_t  designs_dat [`NUM_TEAMS:0];
    logic                  in_designs;
    logic                  in_la;
    logic                  in_gpio;

    assign team_sel   = wbs_adr_i[23:16];
    assign in_designs = (wbs_adr_i[31:24] == `REGION_DESIGN);
    assign in_la      = (wbs_adr_i[31:16] == `REGION_LA);
    assign in_gpio    = (wbs_adr_i[31:16] == `REGION_GPIO);

    // Slaves only decode the low half
    assign adr_truncated_o = {16'h0000, wbs_adr_i[15:0]};

    always_comb begin
        for (int i = 0; i <= `NUM_TEAMS; i++) begin
            designs_dat[i] = designs_wbs_dat_o_flat[i*32 +: 32];
        end
    end

    assign la_control_stb_o   = in_la & wbs_stb_i;
    assign gpio_control_stb_o = in_gpio & wbs_stb_i;

    // Team 0 has no slot, so its strobe stays low
    always_comb begin
        designs_stb_o = '0;
        for (int i = 1; i <= `NUM_TEAMS; i++) begin
            if (in_designs && team_sel == wb_mux_pkg::team_sel_t'(i)) begin
                designs_stb_o[i] = wbs_stb_i;
            end
        end
    end

    // Return path, zero when nothing is addressed
    always_comb begin
        wbs_dat_o = '0;
        wbs_ack_o = 1'b0;
        if (in_designs) begin
            for (int i = 0; i <= `NUM_TEAMS; i++) begin
                if (team_sel == wb_mux_pkg::team_sel_t'(i)) begin
                    wbs_dat_o = designs_dat[i];
                    wbs_ack_o = designs_ack_i[i];
                end
            end
        end else if (in_la) begin
            wbs_dat_o = la_control_dat_i;
            wbs_ack_o = la_control_ack_i;
        end else if (in_gpio) begin
            wbs_dat_o = gpio_control_dat_i;
            wbs_ack_o = gpio_control_ack_i;
        end
    end

    // At most one target may see a strobe
    always_comb begin
        assert ($onehot0({designs_stb_o, la_control_stb_o, gpio_control_stb_o}))
            else $error("more than one slave strobe active");
    end

endmodule

//--- rtl/la_control.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module la_control (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    // Bus slave
    input  logic                 stb_i,
    input  logic                 we_i,
    input  wb_mux_pkg::wb_addr_t adr_i,
    input  wb_mux_pkg::wb_data_t dat_i,
    output logic                 ack_o,
    output wb_mux_pkg::wb_data_t dat_o,

    // Logic analyzer pins
    input  wb_mux_pkg::wb_data_t la_data_i,
    output wb_mux_pkg::wb_data_t la_data_o,
    output wb_mux_pkg::wb_data_t la_oen_o
);

    wb_mux_pkg::bus_state_t  state_q;
    wb_mux_pkg::reg_offset_t offset;
    wb_mux_pkg::wb_data_t    la_data_q;
    wb_mux_pkg::wb_data_t    la_oen_q;
    wb_mux_pkg::wb_data_t    rd_word;
    wb_mux_pkg::wb_data_t    rd_q;
    logic                    access;

    assign offset = adr_i[15:0];
    assign access = (state_q == wb_mux_pkg::BUS_IDLE) && stb_i;

    // Ack FSM, one pulse per strobe
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (state_q == wb_mux_pkg::BUS_ACK) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (stb_i) begin
            state_q <= wb_mux_pkg::BUS_ACK;
        end
    end

    always_comb begin
        case (offset)
            `OFS_DATA: rd_word = la_data_q;
            `OFS_OEN:  rd_word = la_oen_q;
            `OFS_IN:   rd_word = la_data_i;
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            la_data_q <= '0;
            la_oen_q  <= '0;
            rd_q      <= '0;
        end else if (access) begin
            if (we_i) begin
                if (offset == `OFS_DATA) la_data_q <= dat_i;
                if (offset == `OFS_OEN) la_oen_q <= dat_i;
            end else begin
                rd_q <= rd_word;
            end
        end
    end

    assign ack_o     = (state_q == wb_mux_pkg::BUS_ACK);
    assign dat_o     = rd_q;
    assign la_data_o = la_data_q;
    assign la_oen_o  = la_oen_q;

    // Master holds stb through the ack, so a second ack would double the access
    ack_single_cycle: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i) ack_o |=> !ack_o
    ) else $error("la_control ack held for two cycles");

endmodule

//--- rtl/gpio_control.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module gpio_control (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,

    // Bus slave
    input  logic                  stb_i,
    input  logic                  we_i,
    input  wb_mux_pkg::wb_addr_t  adr_i,
    input  wb_mux_pkg::wb_data_t  dat_i,
    output logic                  ack_o,
    output wb_mux_pkg::wb_data_t  dat_o,

    // Pads
    input  wb_mux_pkg::gpio_vec_t gpio_in_i,
    output wb_mux_pkg::gpio_vec_t gpio_out_o,
    output wb_mux_pkg::gpio_vec_t gpio_oe_o
);

    wb_mux_pkg::bus_state_t  state_q;
    wb_mux_pkg::reg_offset_t offset;
    wb_mux_pkg::gpio_vec_t   gpio_out_q;
    wb_mux_pkg::gpio_vec_t   gpio_oe_q;
    wb_mux_pkg::gpio_vec_t   gpio_meta_q;
    wb_mux_pkg::gpio_vec_t   gpio_sync_q;
    wb_mux_pkg::wb_data_t    rd_word;
    wb_mux_pkg::wb_data_t    rd_q;
    logic                    access;

    assign offset = adr_i[15:0];
    assign access = (state_q == wb_mux_pkg::BUS_IDLE) && stb_i;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (state_q == wb_mux_pkg::BUS_ACK) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (stb_i) begin
            state_q <= wb_mux_pkg::BUS_ACK;
        end
    end

    // Pads are asynchronous, two flops before anything reads them
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_meta_q <= '0;
            gpio_sync_q <= '0;
        end else begin
            gpio_meta_q <= gpio_in_i;
            gpio_sync_q <= gpio_meta_q;
        end
    end

    // Narrow registers read back zero-extended
    always_comb begin
        case (offset)
            `OFS_DATA: rd_word = wb_mux_pkg::wb_data_t'(gpio_out_q);
            `OFS_OEN:  rd_word = wb_mux_pkg::wb_data_t'(gpio_oe_q);
            `OFS_IN:   rd_word = wb_mux_pkg::wb_data_t'(gpio_sync_q);
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_out_q <= '0;
            gpio_oe_q  <= '0;
            rd_q       <= '0;
        end else if (access) begin
            if (we_i) begin
                if (offset == `OFS_DATA) gpio_out_q <= dat_i[`GPIO_WIDTH-1:0];
                if (offset == `OFS_OEN) gpio_oe_q <= dat_i[`GPIO_WIDTH-1:0];
            end else begin
                rd_q <= rd_word;
            end
        end
    end

    assign ack_o      = (state_q == wb_mux_pkg::BUS_ACK);
    assign dat_o      = rd_q;
    assign gpio_out_o = gpio_out_q;
    assign gpio_oe_o  = gpio_oe_q;

    ack_single_cycle: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i) ack_o |=> !ack_o
    ) else $error("gpio_control ack held for two cycles");

endmodule

//--- rtl/team_slot.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module team_slot #(
    parameter int TEAM_ID = 1
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    input  logic                 stb_i,
    input  logic                 we_i,
    input  wb_mux_pkg::wb_addr_t adr_i,
    input  wb_mux_pkg::wb_data_t dat_i,
    output logic                 ack_o,
    output wb_mux_pkg::wb_data_t dat_o
);

    wb_mux_pkg::bus_state_t  state_q;
    wb_mux_pkg::reg_offset_t offset;
    wb_mux_pkg::wb_data_t    scratch_q;
    wb_mux_pkg::wb_data_t    count_q;
    wb_mux_pkg::wb_data_t    rd_word;
    wb_mux_pkg::wb_data_t    rd_q;
    logic                    access;

    assign offset = adr_i[15:0];
    assign access = (state_q == wb_mux_pkg::BUS_IDLE) && stb_i;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (state_q == wb_mux_pkg::BUS_ACK) begin
            state_q <= wb_mux_pkg::BUS_IDLE;
        end else if (stb_i) begin
            state_q <= wb_mux_pkg::BUS_ACK;
        end
    end

    // Count read here is the value before this access
    always_comb begin
        case (offset)
            `OFS_SCRATCH: rd_word = scratch_q;
            `OFS_ID:      rd_word = wb_mux_pkg::wb_data_t'(TEAM_ID);
            `OFS_COUNT:   rd_word = count_q;
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scratch_q <= '0;
            count_q   <= '0;
            rd_q      <= '0;
        end else if (access) begin
            count_q <= count_q + 1'b1;
            if (we_i) begin
                if (offset == `OFS_SCRATCH) scratch_q <= dat_i;
            end else begin
                rd_q <= rd_word;
            end
        end
    end

    assign ack_o = (state_q == wb_mux_pkg::BUS_ACK);
    assign dat_o = rd_q;

    // Strobe comes through the interconnect decode, so a stray ack means a decode fault
    ack_needs_stb: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i) $rose(ack_o) |-> $past(stb_i)
    ) else $error("team_slot %0d acked without a strobe", TEAM_ID);

endmodule

//--- rtl/wb_subsystem_top.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module wb_subsystem_top (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,

    // Wishbone master side
    input  logic                  wbs_stb_i,
    input  logic                  wbs_we_i,
    input  wb_mux_pkg::wb_addr_t  wbs_adr_i,
    input  wb_mux_pkg::wb_data_t  wbs_dat_i,
    output logic                  wbs_ack_o,
    output wb_mux_pkg::wb_data_t  wbs_dat_o,

    // Logic analyzer pins
    input  wb_mux_pkg::wb_data_t  la_data_i,
    output wb_mux_pkg::wb_data_t  la_data_o,
    output wb_mux_pkg::wb_data_t  la_oen_o,

    // GPIO pads
    input  wb_mux_pkg::gpio_vec_t gpio_in_i,
    output wb_mux_pkg::gpio_vec_t gpio_out_o,
    output wb_mux_pkg::gpio_vec_t gpio_oe_o
);

    logic [`NUM_TEAMS:0]          designs_stb;
    logic                         la_control_stb;
    logic                         gpio_control_stb;
    wb_mux_pkg::wb_addr_t         adr_truncated;
    wire [32*(`NUM_TEAMS+1)-1:0]  designs_dat_flat;
    wire [`NUM_TEAMS:0]           designs_ack;
    wb_mux_pkg::wb_data_t         la_control_dat;
    wb_mux_pkg::wb_data_t         gpio_control_dat;
    logic                         la_control_ack;
    logic                         gpio_control_ack;

    // No slot behind team 0
    assign designs_dat_flat[31:0] = '0;
    assign designs_ack[0]         = 1'b0;

    wb_interconnect u_interconnect (
        .wbs_stb_i              (wbs_stb_i),
        .wbs_adr_i              (wbs_adr_i),
        .wbs_ack_o              (wbs_ack_o),
        .wbs_dat_o              (wbs_dat_o),
        .designs_stb_o          (designs_stb),
        .la_control_stb_o       (la_control_stb),
        .gpio_control_stb_o     (gpio_control_stb),
        .adr_truncated_o        (adr_truncated),
        .designs_wbs_dat_o_flat (designs_dat_flat),
        .la_control_dat_i       (la_control_dat),
        .gpio_control_dat_i     (gpio_control_dat),
        .designs_ack_i          (designs_ack),
        .la_control_ack_i       (la_control_ack),
        .gpio_control_ack_i     (gpio_control_ack)
    );

    la_control u_la_control (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .stb_i     (la_control_stb),
        .we_i      (wbs_we_i),
        .adr_i     (adr_truncated),
        .dat_i     (wbs_dat_i),
        .ack_o     (la_control_ack),
        .dat_o     (la_control_dat),
        .la_data_i (la_data_i),
        .la_data_o (la_data_o),
        .la_oen_o  (la_oen_o)
    );

    gpio_control u_gpio_control (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .stb_i      (gpio_control_stb),
        .we_i       (wbs_we_i),
        .adr_i      (adr_truncated),
        .dat_i      (wbs_dat_i),
        .ack_o      (gpio_control_ack),
        .dat_o      (gpio_control_dat),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

    // One register block per team, read data packed by team number
    for (genvar t = 1; t <= `NUM_TEAMS; t++) begin : g_team
        team_slot #(
            .TEAM_ID(t)
        ) u_team_slot (
            .wb_clk_i (wb_clk_i),
            .rst_n_i  (rst_n_i),
            .stb_i    (designs_stb[t]),
            .we_i     (wbs_we_i),
            .adr_i    (adr_truncated),
            .dat_i    (wbs_dat_i),
            .ack_o    (designs_ack[t]),
            .dat_o    (designs_dat_flat[t*32 +: 32])
        );
    end

endmodule

//--- verification/tb_wb_subsystem.sv
`timescale 1ns/1ps

`include "wb_mux_cfg.svh"

module tb_wb_subsystem;

    localparam int ACK_WAIT_CYCLES = 8;
    // Roughly 60 bus cycles of up to 10 clocks each, with a wide margin
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int COUNT_EXTRA_OPS = 3;

    logic                  wb_clk_i;
    logic                  rst_n_i;
    logic                  wbs_stb_i;
    logic                  wbs_we_i;
    wb_mux_pkg::wb_addr_t  wbs_adr_i;
    wb_mux_pkg::wb_data_t  wbs_dat_i;
    logic                  wbs_ack_o;
    wb_mux_pkg::wb_data_t  wbs_dat_o;
    wb_mux_pkg::wb_data_t  la_data_i;
    wb_mux_pkg::wb_data_t  la_data_o;
    wb_mux_pkg::wb_data_t  la_oen_o;
    wb_mux_pkg::gpio_vec_t gpio_in_i;
    wb_mux_pkg::gpio_vec_t gpio_out_o;
    wb_mux_pkg::gpio_vec_t gpio_oe_o;

    integer                seed;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    // Reference copies of what the registers should hold
    wb_mux_pkg::wb_data_t  la_data_exp;
    wb_mux_pkg::gpio_vec_t gpio_out_exp;
    wb_mux_pkg::wb_data_t  scratch_exp [1:`NUM_TEAMS];

    wb_subsystem_top dut0 (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o),
        .la_data_i  (la_data_i),
        .la_data_o  (la_data_o),
        .la_oen_o   (la_oen_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic wb_mux_pkg::wb_addr_t team_addr(input int team,
                                                       input wb_mux_pkg::reg_offset_t ofs);
        return {`REGION_DESIGN, wb_mux_pkg::team_sel_t'(team), ofs};
    endfunction

    function automatic wb_mux_pkg::wb_addr_t la_addr(input wb_mux_pkg::reg_offset_t ofs);
        return {`REGION_LA, ofs};
    endfunction

    function automatic wb_mux_pkg::wb_addr_t gpio_addr(input wb_mux_pkg::reg_offset_t ofs);
        return {`REGION_GPIO, ofs};
    endfunction

    task automatic check_data(input wb_mux_pkg::wb_data_t got, input wb_mux_pkg::wb_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_gpio(input wb_mux_pkg::gpio_vec_t got,
                              input wb_mux_pkg::gpio_vec_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_noack(input logic seen, input logic expected, input string what);
        if (seen !== expected) begin
            if (expected) begin
                $display("No acknowledge came for %s (time %0t)", what, $time);
            end else begin
                $display("An acknowledge came for %s, none was due (time %0t)", what, $time);
            end
            errors++;
        end
    endtask

    // One strobe held until ack or until the wait runs out, sampled mid-cycle
    task automatic bus_cycle(input wb_mux_pkg::wb_addr_t addr, input logic we,
                             input wb_mux_pkg::wb_data_t data,
                             output wb_mux_pkg::wb_data_t rdata, output logic got);
        int cycles;
        @(posedge wb_clk_i);
        #1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = addr;
        wbs_dat_i = data;
        got       = 1'b0;
        rdata     = '0;
        cycles    = 0;
        while (!got && cycles < ACK_WAIT_CYCLES) begin
            @(negedge wb_clk_i);
            got   = wbs_ack_o;
            rdata = wbs_dat_o;
            cycles++;
        end
        @(posedge wb_clk_i);
        #1;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_mux_pkg::wb_addr_t addr, input wb_mux_pkg::wb_data_t data,
                            input string what);
        wb_mux_pkg::wb_data_t unused;
        logic                 got;
        bus_cycle(addr, 1'b1, data, unused, got);
        check_noack(got, 1'b1, what);
    endtask

    task automatic wb_read(input wb_mux_pkg::wb_addr_t addr,
                           output wb_mux_pkg::wb_data_t rdata, input string what);
        logic got;
        bus_cycle(addr, 1'b0, '0, rdata, got);
        check_noack(got, 1'b1, what);
    endtask

    task automatic wb_probe_none(input wb_mux_pkg::wb_addr_t addr, input string what);
        wb_mux_pkg::wb_data_t unused;
        logic                 got;
        bus_cycle(addr, 1'b1, 32'hdead_beef, unused, got);
        check_noack(got, 1'b0, what);
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%-18s passed", name);
        end else begin
            tests_failed++;
            $display("%-18s failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic test_reset_state();
        int                   errs;
        wb_mux_pkg::wb_data_t rd;
        wb_mux_pkg::wb_addr_t idle_addrs [$];
        errs = errors;
        check_data(la_oen_o, '0, "la_oen_o after reset");
        check_gpio(gpio_oe_o, '0, "gpio_oe_o after reset");
        // Point at each slave in turn so its own ack reaches the master
        idle_addrs.push_back(la_addr(`OFS_DATA));
        idle_addrs.push_back(gpio_addr(`OFS_DATA));
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            idle_addrs.push_back(team_addr(t, `OFS_ID));
        end
        foreach (idle_addrs[i]) begin
            wbs_adr_i = idle_addrs[i];
            @(negedge wb_clk_i);
            check_noack(wbs_ack_o, 1'b0,
                        $sformatf("the idle bus at %h after reset", idle_addrs[i]));
            @(posedge wb_clk_i);
            #1;
        end
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            wb_read(team_addr(t, `OFS_COUNT), rd, $sformatf("team %0d first count read", t));
            check_data(rd, '0, $sformatf("team %0d first count", t));
        end
        report_test("reset_state", errs);
    endtask

    task automatic test_la_control();
        int                   errs;
        wb_mux_pkg::wb_data_t oen;
        wb_mux_pkg::wb_data_t rd;
        errs        = errors;
        la_data_exp = $random(seed);
        oen         = $random(seed);
        wb_write(la_addr(`OFS_DATA), la_data_exp, "LA data write");
        check_data(la_data_o, la_data_exp, "la_data_o");
        wb_write(la_addr(`OFS_OEN), oen, "LA enable write");
        check_data(la_oen_o, oen, "la_oen_o");
        wb_read(la_addr(`OFS_DATA), rd, "LA data read");
        check_data(rd, la_data_exp, "LA data readback");
        wb_read(la_addr(`OFS_OEN), rd, "LA enable read");
        check_data(rd, oen, "LA enable readback");
        @(posedge wb_clk_i);
        #1;
        la_data_i = $random(seed);
        wb_read(la_addr(`OFS_IN), rd, "LA input read");
        check_data(rd, la_data_i, "LA input readback");
        report_test("la_control", errs);
    endtask

    task automatic test_gpio_control();
        int                    errs;
        wb_mux_pkg::wb_data_t  word;
        wb_mux_pkg::gpio_vec_t pads;
        wb_mux_pkg::wb_data_t  rd;
        errs         = errors;
        word         = $random(seed);
        gpio_out_exp = word[`GPIO_WIDTH-1:0];
        wb_write(gpio_addr(`OFS_DATA), word, "GPIO output write");
        check_gpio(gpio_out_o, gpio_out_exp, "gpio_out_o");
        word = $random(seed);
        wb_write(gpio_addr(`OFS_OEN), word, "GPIO enable write");
        check_gpio(gpio_oe_o, word[`GPIO_WIDTH-1:0], "gpio_oe_o");
        wb_read(gpio_addr(`OFS_OEN), rd, "GPIO enable read");
        check_data(rd, {16'h0000, word[`GPIO_WIDTH-1:0]}, "GPIO enable readback");
        pads = $random(seed);
        @(posedge wb_clk_i);
        #1;
        gpio_in_i = pads;
        // Two synchronizer flops plus one spare cycle
        repeat (3) @(posedge wb_clk_i);
        wb_read(gpio_addr(`OFS_IN), rd, "GPIO input read");
        check_data(rd, {16'h0000, pads}, "GPIO input readback");
        report_test("gpio_control", errs);
    endtask

    task automatic test_team_slots();
        int                   errs;
        wb_mux_pkg::wb_data_t word;
        wb_mux_pkg::wb_data_t rd;
        errs = errors;
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            wb_read(team_addr(t, `OFS_ID), rd, $sformatf("team %0d id read", t));
            check_data(rd, t, $sformatf("team %0d id", t));
        end
        // Team number in the top byte keeps every value distinct
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            word           = $random(seed);
            scratch_exp[t] = {8'(t), word[23:0]};
            wb_write(team_addr(t, `OFS_SCRATCH), scratch_exp[t],
                     $sformatf("team %0d scratch write", t));
        end
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            wb_read(team_addr(t, `OFS_SCRATCH), rd, $sformatf("team %0d scratch read", t));
            check_data(rd, scratch_exp[t], $sformatf("team %0d scratch", t));
        end
        report_test("team_slots", errs);
    endtask

    task automatic test_access_counter();
        int                   errs;
        wb_mux_pkg::wb_data_t first;
        wb_mux_pkg::wb_data_t last;
        wb_mux_pkg::wb_data_t rd;
        errs = errors;
        wb_read(team_addr(2, `OFS_COUNT), first, "team 2 count read");
        scratch_exp[2] = scratch_exp[2] ^ 32'h0000_ffff;
        wb_write(team_addr(2, `OFS_SCRATCH), scratch_exp[2], "team 2 scratch write");
        wb_read(team_addr(2, `OFS_ID), rd, "team 2 id read");
        wb_read(team_addr(2, `OFS_SCRATCH), rd, "team 2 scratch read");
        wb_read(team_addr(2, `OFS_COUNT), last, "team 2 count reread");
        check_data(last, first + COUNT_EXTRA_OPS + 1, "team 2 access count");
        report_test("access_counter", errs);
    endtask

    task automatic test_decode_limits();
        int                   errs;
        wb_mux_pkg::wb_data_t rd;
        errs = errors;
        wb_probe_none(team_addr(0, `OFS_SCRATCH), "a write to team 0");
        wb_probe_none(team_addr(`NUM_TEAMS + 1, `OFS_SCRATCH), "a write past the last team");
        wb_probe_none({16'h3300, `OFS_DATA}, "a write to region 3300");
        for (int t = 1; t <= `NUM_TEAMS; t++) begin
            wb_read(team_addr(t, `OFS_SCRATCH), rd, $sformatf("team %0d scratch read", t));
            check_data(rd, scratch_exp[t], $sformatf("team %0d scratch after probes", t));
        end
        wb_read(la_addr(`OFS_DATA), rd, "LA data read");
        check_data(rd, la_data_exp, "LA data after probes");
        check_gpio(gpio_out_o, gpio_out_exp, "gpio_out_o after probes");
        wb_read(la_addr(16'h000c), rd, "LA unused offset read");
        check_data(rd, '0, "LA unused offset");
        report_test("decode_limits", errs);
    endtask

    initial begin
        seed         = 24513;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n_i      = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_adr_i    = '0;
        wbs_dat_i    = '0;
        la_data_i    = '0;
        gpio_in_i    = '0;
        repeat (2) @(posedge wb_clk_i);
        #1;
        rst_n_i = 1'b1;

        test_reset_state();
        test_la_control();
        test_gpio_control();
        test_team_slots();
        test_access_counter();
        test_decode_limits();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/wb_mux_pkg.sv
rtl/wb_interconnect.sv
rtl/la_control.sv
rtl/gpio_control.sv
rtl/team_slot.sv
rtl/wb_subsystem_top.sv
verification/tb_wb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_wb_subsystem -o Vtb_wb_subsystem || exit 1

# A crashed or aborted run counts as a failure in the log
./obj_dir/Vtb_wb_subsystem > "$LOG" 2>&1 || echo "FAIL: see errors above" >> "$LOG"
cat "$LOG"

grep -q "FAIL: see errors above" "$LOG" && exit 1 || exit 0
